// File: Bender.yml
package:
  name: core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_pkg.sv
      - hw/pipe_reg.sv
      - hw/instr_mem.sv
      - hw/reg_file.sv
      - hw/alu.sv
      - hw/net_ctrl.sv
      - hw/core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/core_tb.sv

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module alu import core_pkg::*;
(
    input  instruction_t                  instr_i,
    input  wire logic [`CORE_DATA_W-1:0]  rs_val_i,
    input  wire logic [`CORE_DATA_W-1:0]  rd_val_i,
    output logic      [`CORE_DATA_W-1:0]  result_o,
    output logic                          branch_taken_o
);

    // Arithmetic and moves
    always_comb
    begin
        unique case (instr_i.opcode)
            OP_ADDU:
                result_o = rd_val_i + rs_val_i;
            OP_SUBU:
                result_o = rd_val_i - rs_val_i;
            OP_AND:
                result_o = rd_val_i & rs_val_i;
            OP_OR:
                result_o = rd_val_i | rs_val_i;
            // JALR target, BAR value and MOV source all come from rs
            OP_MOV, OP_BAR, OP_JALR:
                result_o = rs_val_i;
            default:
                result_o = '0;
        endcase
    end

    // Branch conditions test the signed rd value against zero
    always_comb
    begin
        unique case (instr_i.opcode)
            OP_BEQZ:
                branch_taken_o = (rd_val_i == '0);
            OP_BNEQZ:
                branch_taken_o = (rd_val_i != '0);
            OP_BLTZ:
                branch_taken_o = $signed(rd_val_i) < 0;
            OP_BGTZ:
                branch_taken_o = $signed(rd_val_i) > 0;
            default:
                branch_taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module core import core_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         n_reset,
    input  wire logic [`CORE_NET_ID_W-1:0]    net_id_i,
    input  net_op_e                           net_op_i,
    input  wire logic [`CORE_NET_ADDR_W-1:0]  net_addr_i,
    input  wire logic [`CORE_DATA_W-1:0]      net_data_i,
    output logic      [`CORE_MASK_W-1:0]      barrier_o,
    output logic                              exception_o
);

    logic [`CORE_IMEM_AW-1:0]  pc_r;
    logic [`CORE_IMEM_AW-1:0]  pc_next;
    logic [`CORE_IMEM_AW-1:0]  br_target;
    logic [`CORE_IMEM_AW-1:0]  imem_addr;
    instruction_t              imem_instr;
    if_id_t                    if_id_d;
    if_id_t                    if_id_q;
    id_ex_t                    id_ex_d;
    id_ex_t                    id_ex_q;
    ex_wb_t                    ex_wb_d;
    ex_wb_t                    ex_wb_q;
    logic [`CORE_DATA_W-1:0]   rf_rs_val;
    logic [`CORE_DATA_W-1:0]   rf_rd_val;
    logic [`CORE_DATA_W-1:0]   alu_result;
    logic                      branch_taken;
    logic                      rf_wen;
    logic [`CORE_RF_AW-1:0]    rf_w_addr;
    logic [`CORE_DATA_W-1:0]   rf_w_data;
    logic [`CORE_DATA_W-1:0]   wb_link;
    logic                      imem_wen;
    logic                      rf_net_wen;
    logic                      pc_load;
    logic                      run;
    logic                      stall;
    logic                      flush_if_id;
    logic                      id_writes_rf;

    net_ctrl u_net_ctrl (
        .clk          (clk),
        .n_reset      (n_reset),
        .net_id_i     (net_id_i),
        .net_op_i     (net_op_i),
        .net_addr_i   (net_addr_i),
        .net_data_i   (net_data_i),
        .wb_instr_i   (ex_wb_q.instr),
        .stall_i      (stall),
        .wb_bar_val_i (ex_wb_q.w_val),
        .imem_wen_o   (imem_wen),
        .rf_net_wen_o (rf_net_wen),
        .pc_load_o    (pc_load),
        .run_o        (run),
        .barrier_o    (barrier_o),
        .exception_o  (exception_o)
    );

    // Pipeline freezes outside RUN, on an instruction load,
    // and when a network register write collides with write-back
    assign stall = !run || imem_wen || (rf_net_wen && ex_wb_q.wen);

    // Next PC, start address first, then EX redirects
    assign br_target = id_ex_q.pc
        + {{(`CORE_IMEM_AW-`CORE_RF_AW){id_ex_q.instr.rs_imm[`CORE_RF_AW-1]}},
           id_ex_q.instr.rs_imm};

    always_comb
    begin
        if (pc_load)
            pc_next = net_addr_i[`CORE_IMEM_AW-1:0];
        else if (stall)
            pc_next = pc_r;
        else if (id_ex_q.instr.opcode == OP_JALR)
            pc_next = alu_result[`CORE_IMEM_AW-1:0];
        else if (branch_taken)
            pc_next = br_target;
        else
            pc_next = pc_r + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            pc_r <= '0;
        else
            pc_r <= pc_next;
    end

    // Memory reads the next PC so its output lines up with pc_r
    assign imem_addr = imem_wen ? net_addr_i[`CORE_IMEM_AW-1:0] : pc_next;

    instr_mem u_imem (
        .clk     (clk),
        .addr_i  (imem_addr),
        .wen_i   (imem_wen),
        .instr_i (net_data_i[$bits(instruction_t)-1:0]),
        .instr_o (imem_instr)
    );

    // IF/ID, fetch stops while JALR or WAIT is in flight
    assign flush_if_id = branch_taken
        || (if_id_q.instr.opcode == OP_JALR) || (if_id_q.instr.opcode == OP_WAIT)
        || (id_ex_q.instr.opcode == OP_JALR) || (id_ex_q.instr.opcode == OP_WAIT)
        || (ex_wb_q.instr.opcode == OP_WAIT);

    assign if_id_d.instr = imem_instr;
    assign if_id_d.pc    = pc_r;

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk     (clk),
        .n_reset (n_reset),
        .hold_i  (stall),
        .flush_i (flush_if_id),
        .d_i     (if_id_d),
        .q_o     (if_id_q)
    );

    reg_file u_rf (
        .clk       (clk),
        .rs_addr_i (if_id_q.instr.rs_imm),
        .rd_addr_i (if_id_q.instr.rd),
        .w_addr_i  (rf_w_addr),
        .wen_i     (rf_wen),
        .w_data_i  (rf_w_data),
        .rs_val_o  (rf_rs_val),
        .rd_val_o  (rf_rd_val)
    );

    // Writes to register 0 are dropped here so forwarding never sees them
    assign id_writes_rf = (if_id_q.instr.rd != '0)
        && (if_id_q.instr.opcode inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_MOV, OP_JALR});

    // Decode and forwarding, EX result beats WB result beats the register file
    // JALR never needs forwarding since fetch is stopped until it commits
    always_comb
    begin
        id_ex_d.instr   = if_id_q.instr;
        id_ex_d.pc      = if_id_q.pc;
        id_ex_d.rd_addr = if_id_q.instr.rd;
        id_ex_d.wen     = id_writes_rf;

        if (id_ex_q.wen && (id_ex_q.rd_addr == if_id_q.instr.rs_imm))
            id_ex_d.rs_val = alu_result;
        else if (ex_wb_q.wen && (ex_wb_q.w_addr == if_id_q.instr.rs_imm))
            id_ex_d.rs_val = ex_wb_q.w_val;
        else
            id_ex_d.rs_val = rf_rs_val;

        if (id_ex_q.wen && (id_ex_q.rd_addr == if_id_q.instr.rd))
            id_ex_d.rd_val = alu_result;
        else if (ex_wb_q.wen && (ex_wb_q.w_addr == if_id_q.instr.rd))
            id_ex_d.rd_val = ex_wb_q.w_val;
        else
            id_ex_d.rd_val = rf_rd_val;
    end

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk     (clk),
        .n_reset (n_reset),
        .hold_i  (stall),
        .flush_i (branch_taken),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    alu u_alu (
        .instr_i        (id_ex_q.instr),
        .rs_val_i       (id_ex_q.rs_val),
        .rd_val_i       (id_ex_q.rd_val),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    assign ex_wb_d.instr  = id_ex_q.instr;
    assign ex_wb_d.pc     = id_ex_q.pc;
    assign ex_wb_d.w_addr = id_ex_q.rd_addr;
    assign ex_wb_d.w_val  = alu_result;
    assign ex_wb_d.wen    = id_ex_q.wen;

    // Nothing younger is ever flushed out of WB
    pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk     (clk),
        .n_reset (n_reset),
        .hold_i  (stall),
        .flush_i (1'b0),
        .d_i     (ex_wb_d),
        .q_o     (ex_wb_q)
    );

    // Write-back, network register writes take the port first
    assign wb_link = {{(`CORE_DATA_W-`CORE_IMEM_AW){1'b0}}, ex_wb_q.pc + 1'b1};

    assign rf_wen    = rf_net_wen || (ex_wb_q.wen && !stall);
    assign rf_w_addr = rf_net_wen ? net_addr_i[`CORE_RF_AW-1:0] : ex_wb_q.w_addr;

    always_comb
    begin
        if (rf_net_wen)
            rf_w_data = net_data_i;
        else if (ex_wb_q.instr.opcode == OP_JALR)
            // Link address
            rf_w_data = wb_link;
        else
            rf_w_data = ex_wb_q.w_val;
    end

endmodule

`default_nettype wire

// File: hw/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath word width
`define CORE_DATA_W 32

// Instruction memory depth is 2**CORE_IMEM_AW, which is also the PC width
`define CORE_IMEM_AW 8

// Register address width, 32 registers
`define CORE_RF_AW 5

// Barrier mask and value width
`define CORE_MASK_W 8

// Network field widths
`define CORE_NET_ID_W 10
`define CORE_NET_ADDR_W 10

// ID this core answers to on the network
`define CORE_NODE_ID 10'd1

`endif

// File: hw/core_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

    // Instruction codes, NOP must stay all zero so a bubble decodes as NOP
    typedef enum logic [5:0]
    {
        OP_NOP   = 6'd0,
        OP_ADDU  = 6'd1,
        OP_SUBU  = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_MOV   = 6'd5,
        OP_BEQZ  = 6'd6,
        OP_BNEQZ = 6'd7,
        OP_BLTZ  = 6'd8,
        OP_BGTZ  = 6'd9,
        OP_JALR  = 6'd10,
        OP_BAR   = 6'd11,
        OP_WAIT  = 6'd12
    } opcode_e;

    // 16-bit instruction word
    // For branches rs_imm is a signed offset from the branch PC
    typedef struct packed
    {
        opcode_e                 opcode;
        logic [`CORE_RF_AW-1:0]  rd;
        logic [`CORE_RF_AW-1:0]  rs_imm;
    } instruction_t;

    // Network commands, NET_NONE marks an idle network cycle
    typedef enum logic [2:0]
    {
        NET_NONE  = 3'd0,
        NET_INSTR = 3'd1,
        NET_REG   = 3'd2,
        NET_PC    = 3'd3,
        NET_BAR   = 3'd4
    } net_op_e;

    // Run state of the core
    typedef enum logic [1:0]
    {
        IDLE = 2'd0,
        RUN  = 2'd1,
        ERR  = 2'd2
    } state_e;

    // IF/ID payload
    typedef struct packed
    {
        instruction_t              instr;
        logic [`CORE_IMEM_AW-1:0]  pc;
    } if_id_t;

    // ID/EX payload, operand values already forwarded
    typedef struct packed
    {
        instruction_t              instr;
        logic [`CORE_IMEM_AW-1:0]  pc;
        logic [`CORE_RF_AW-1:0]    rd_addr;
        logic [`CORE_DATA_W-1:0]   rs_val;
        logic [`CORE_DATA_W-1:0]   rd_val;
        logic                      wen;
    } id_ex_t;

    // EX/WB payload
    typedef struct packed
    {
        instruction_t              instr;
        logic [`CORE_IMEM_AW-1:0]  pc;
        logic [`CORE_RF_AW-1:0]    w_addr;
        logic [`CORE_DATA_W-1:0]   w_val;
        logic                      wen;
    } ex_wb_t;

endpackage

`default_nettype wire

// File: hw/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module instr_mem import core_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic [`CORE_IMEM_AW-1:0]  addr_i,
    input  wire logic                      wen_i,
    input  instruction_t                   instr_i,
    output instruction_t                   instr_o
);

    instruction_t mem [2**`CORE_IMEM_AW];

    // Single port, registered read
    always_ff @(posedge clk)
    begin
        if (wen_i)
        begin
            // A write leaves the read register alone
            // so a fetch stalled behind a load is not lost
            mem[addr_i] <= instr_i;
        end
        else
        begin
            instr_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

// File: hw/net_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module net_ctrl import core_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         n_reset,
    input  wire logic [`CORE_NET_ID_W-1:0]    net_id_i,
    input  net_op_e                           net_op_i,
    input  wire logic [`CORE_NET_ADDR_W-1:0]  net_addr_i,
    input  wire logic [`CORE_DATA_W-1:0]      net_data_i,
    input  instruction_t                      wb_instr_i,
    input  wire logic                         stall_i,
    input  wire logic [`CORE_DATA_W-1:0]      wb_bar_val_i,
    output logic                              imem_wen_o,
    output logic                              rf_net_wen_o,
    output logic                              pc_load_o,
    output logic                              run_o,
    output logic      [`CORE_MASK_W-1:0]      barrier_o,
    output logic                              exception_o
);

    state_e                   state_r;
    logic [`CORE_MASK_W-1:0]  mask_r;
    logic [`CORE_MASK_W-1:0]  bar_val_r;
    logic                     id_match;
    logic                     pc_cmd;
    logic                     bar_cmd;
    logic                     commit_bar;
    logic                     commit_wait;

    // Packet decode, only packets for this node count
    assign id_match     = (net_id_i == `CORE_NODE_ID);
    assign imem_wen_o   = id_match && (net_op_i == NET_INSTR);
    assign rf_net_wen_o = id_match && (net_op_i == NET_REG);
    assign pc_cmd       = id_match && (net_op_i == NET_PC);
    assign bar_cmd      = id_match && (net_op_i == NET_BAR);

    // Start is only accepted from IDLE
    assign pc_load_o = pc_cmd && (state_r == IDLE);
    assign run_o     = (state_r == RUN);

    // Instructions commit from WB only in a cycle that is not stalled
    assign commit_bar  = !stall_i && (wb_instr_i.opcode == OP_BAR);
    assign commit_wait = !stall_i && (wb_instr_i.opcode == OP_WAIT);

    // Mask bit of 1 lets the value bit through
    assign barrier_o = mask_r & bar_val_r;

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_r     <= IDLE;
            mask_r      <= '0;
            bar_val_r   <= '0;
            exception_o <= 1'b0;
        end
        else
        begin
            // Run state, ERR is left only through reset
            if (pc_cmd && (state_r != IDLE))
            begin
                state_r     <= ERR;
                exception_o <= 1'b1;
            end
            else if (pc_load_o)
            begin
                state_r <= RUN;
            end
            else if (commit_wait && (state_r == RUN))
            begin
                state_r <= IDLE;
            end

            // Mask is frozen once in ERR
            if (bar_cmd && (state_r != ERR))
            begin
                mask_r <= net_data_i[`CORE_MASK_W-1:0];
            end

            // Start packet seeds the value, a committed BAR updates it
            if (pc_load_o)
            begin
                bar_val_r <= net_data_i[`CORE_MASK_W-1:0];
            end
            else if (commit_bar)
            begin
                bar_val_r <= wb_bar_val_i[`CORE_MASK_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
)
(
    input  wire logic clk,
    input  wire logic n_reset,
    input  wire logic hold_i,
    input  wire logic flush_i,
    input  payload_t  d_i,
    output payload_t  q_o
);

    // Hold wins over flush, so a stalled branch keeps its flush
    // request alive until the stall clears
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            q_o <= '0;
        end
        else if (hold_i)
        begin
            q_o <= q_o;
        end
        else if (flush_i)
        begin
            // All zero is a NOP bubble that writes nothing
            q_o <= '0;
        end
        else
        begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module reg_file
(
    input  wire logic                     clk,
    input  wire logic [`CORE_RF_AW-1:0]   rs_addr_i,
    input  wire logic [`CORE_RF_AW-1:0]   rd_addr_i,
    input  wire logic [`CORE_RF_AW-1:0]   w_addr_i,
    input  wire logic                     wen_i,
    input  wire logic [`CORE_DATA_W-1:0]  w_data_i,
    output logic      [`CORE_DATA_W-1:0]  rs_val_o,
    output logic      [`CORE_DATA_W-1:0]  rd_val_o
);

    logic [`CORE_DATA_W-1:0] regs [2**`CORE_RF_AW];

    // Write at the clock edge
    always_ff @(posedge clk)
    begin
        if (wen_i)
        begin
            regs[w_addr_i] <= w_data_i;
        end
    end

    // Combinational read ports
    // Register 0 reads as zero whatever was written to it
    always_comb
    begin
        rs_val_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
        rd_val_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];
    end

endmodule

`default_nettype wire

// File: test/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module core_tb import core_pkg::*;
();

    // About 6 programs of up to 400 cycles each, plus loading
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RUN_BUDGET     = 400;
    localparam int SETTLE_CYCLES  = 8;
    localparam int NO_LIMIT       = 1000;

    logic                         clk;
    logic                         n_reset;
    logic [`CORE_NET_ID_W-1:0]    net_id;
    net_op_e                      net_op;
    logic [`CORE_NET_ADDR_W-1:0]  net_addr;
    logic [`CORE_DATA_W-1:0]      net_data;
    logic [`CORE_MASK_W-1:0]      barrier;
    logic                         exception;

    // Testbench copy of program and registers
    instruction_t             prog_mem [2**`CORE_IMEM_AW];
    logic [`CORE_DATA_W-1:0]  model_regs [2**`CORE_RF_AW];
    logic [`CORE_MASK_W-1:0]  cur_mask;
    logic                     model_err;
    int                       load_pc;
    int                       cycle_cnt = 0;
    integer                   rnd_seed;

    // Request and result of the compare process
    logic                     check_req;
    logic                     check_done;
    logic [`CORE_MASK_W-1:0]  exp_bar;
    logic                     exp_exc;

    core u_dut (
        .clk         (clk),
        .n_reset     (n_reset),
        .net_id_i    (net_id),
        .net_op_i    (net_op),
        .net_addr_i  (net_addr),
        .net_data_i  (net_data),
        .barrier_o   (barrier),
        .exception_o (exception)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, a program never finished", cycle_cnt);
            $display("tests failed");
            $fatal(1, "simulation aborted");
        end
    end

    task automatic check_barrier(input logic [`CORE_MASK_W-1:0] got,
                                 input logic [`CORE_MASK_W-1:0] exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t ns: barrier_o is %h, expected %h", $time, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_exception(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t ns: exception_o is %b, expected %b", $time, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // Register 0 is hard zero
    function automatic logic [`CORE_DATA_W-1:0] read_model_reg(input logic [`CORE_RF_AW-1:0] idx);
        return (idx == '0) ? '0 : model_regs[idx];
    endfunction

    function automatic void write_model_reg(input logic [`CORE_RF_AW-1:0] idx,
                                            input logic [`CORE_DATA_W-1:0] val);
        if (idx != '0)
        begin
            model_regs[idx] = val;
        end
    endfunction

    // ISA model, runs until WAIT or until max_steps instructions
    // Hitting the step limit means the host restarts a running core
    function automatic logic [`CORE_MASK_W-1:0] model_run(input logic [`CORE_IMEM_AW-1:0] start_pc,
                                                          input int max_steps,
                                                          output logic exc);
        logic [`CORE_IMEM_AW-1:0]  pc;
        logic [`CORE_IMEM_AW-1:0]  next_pc;
        logic [`CORE_IMEM_AW-1:0]  target;
        logic [`CORE_MASK_W-1:0]   val;
        logic [`CORE_DATA_W-1:0]   rs_v;
        logic [`CORE_DATA_W-1:0]   rd_v;
        instruction_t              ins;
        int                        offset;
        int                        steps;
        logic                      done;
        pc    = start_pc;
        val   = '0;
        exc   = 1'b0;
        steps = 0;
        done  = 1'b0;
        while (!done)
        begin
            if (steps == max_steps)
            begin
                exc  = 1'b1;
                done = 1'b1;
            end
            else
            begin
                ins     = prog_mem[pc];
                rs_v    = read_model_reg(ins.rs_imm);
                rd_v    = read_model_reg(ins.rd);
                offset  = int'($signed(ins.rs_imm));
                target  = pc + offset[`CORE_IMEM_AW-1:0];
                next_pc = pc + 1'b1;
                steps++;
                pc = next_pc;
                case (ins.opcode)
                    OP_ADDU:  write_model_reg(ins.rd, rd_v + rs_v);
                    OP_SUBU:  write_model_reg(ins.rd, rd_v - rs_v);
                    OP_AND:   write_model_reg(ins.rd, rd_v & rs_v);
                    OP_OR:    write_model_reg(ins.rd, rd_v | rs_v);
                    OP_MOV:   write_model_reg(ins.rd, rs_v);
                    OP_BEQZ:  pc = (rd_v == '0) ? target : next_pc;
                    OP_BNEQZ: pc = (rd_v != '0) ? target : next_pc;
                    OP_BLTZ:  pc = ($signed(rd_v) < 0) ? target : next_pc;
                    OP_BGTZ:  pc = ($signed(rd_v) > 0) ? target : next_pc;
                    OP_JALR:
                    begin
                        // Target comes from the old rs, link is the next PC
                        pc = rs_v[`CORE_IMEM_AW-1:0];
                        write_model_reg(ins.rd, {{(`CORE_DATA_W-`CORE_IMEM_AW){1'b0}}, next_pc});
                    end
                    OP_BAR:   val = rs_v[`CORE_MASK_W-1:0];
                    OP_WAIT:  done = 1'b1;
                    default:  ;
                endcase
            end
        end
        return val;
    endfunction

    // One packet per call, taken at the second edge
    task automatic send_packet(input logic [`CORE_NET_ID_W-1:0] id, input net_op_e op,
                               input logic [`CORE_NET_ADDR_W-1:0] addr,
                               input logic [`CORE_DATA_W-1:0] data);
        @(posedge clk);
        net_id   <= id;
        net_op   <= op;
        net_addr <= addr;
        net_data <= data;
        @(posedge clk);
        net_op   <= NET_NONE;
    endtask

    task automatic put_instr(input opcode_e op, input int rd, input int rs);
        instruction_t ins;
        ins.opcode = op;
        ins.rd     = rd[`CORE_RF_AW-1:0];
        ins.rs_imm = rs[`CORE_RF_AW-1:0];
        prog_mem[load_pc] = ins;
        send_packet(`CORE_NODE_ID, NET_INSTR, load_pc[`CORE_NET_ADDR_W-1:0],
                    {{(`CORE_DATA_W-$bits(instruction_t)){1'b0}}, ins});
        load_pc++;
    endtask

    task automatic load_reg(input int idx, input logic [`CORE_DATA_W-1:0] val);
        model_regs[idx] = val;
        send_packet(`CORE_NODE_ID, NET_REG, idx[`CORE_NET_ADDR_W-1:0], val);
    endtask

    task automatic load_mask(input logic [`CORE_MASK_W-1:0] m);
        // Mask is frozen in ERR
        if (!model_err)
        begin
            cur_mask = m;
        end
        send_packet(`CORE_NODE_ID, NET_BAR, '0, {{(`CORE_DATA_W-`CORE_MASK_W){1'b0}}, m});
    endtask

    // Start a program, optionally restart it mid-run, then hand over to compare
    task automatic run_program(input int start_pc, input int max_steps);
        logic [`CORE_MASK_W-1:0] value;
        logic [`CORE_MASK_W-1:0] seed;
        logic                    exc;
        value = model_run(start_pc[`CORE_IMEM_AW-1:0], max_steps, exc);
        // Each program ends in BAR, seed differs from the result in every bit
        seed = ~value;
        send_packet(`CORE_NODE_ID, NET_PC, start_pc[`CORE_NET_ADDR_W-1:0],
                    {{(`CORE_DATA_W-`CORE_MASK_W){1'b0}}, seed});
        @(negedge clk);
        // Seed visible through the mask before any BAR commits
        check_barrier(barrier, cur_mask & seed);
        if (exc)
        begin
            // Second start arrives inside the long loop
            repeat (40) @(posedge clk);
            send_packet(`CORE_NODE_ID, NET_PC, start_pc[`CORE_NET_ADDR_W-1:0], '0);
            model_err = 1'b1;
        end
        @(negedge clk);
        exp_bar   = cur_mask & value;
        exp_exc   = exc;
        check_req = 1'b1;
        wait (check_done);
        check_req = 1'b0;
        wait (!check_done);
    endtask

    // Wait for the final barrier value, let it settle, then compare
    initial
    begin : compare_proc
        int waited;
        check_done = 1'b0;
        forever
        begin
            wait (check_req);
            waited = 0;
            while ((barrier !== exp_bar) && (waited < RUN_BUDGET))
            begin
                @(negedge clk);
                waited++;
            end
            repeat (SETTLE_CYCLES) @(negedge clk);
            check_barrier(barrier, exp_bar);
            check_exception(exception, exp_exc);
            check_done = 1'b1;
            wait (!check_req);
            check_done = 1'b0;
        end
    end

    initial
    begin : test_seq
        int                       i;
        logic [`CORE_DATA_W-1:0]  rnd;
        n_reset       = 1'b0;
        net_id        = '0;
        net_op        = NET_NONE;
        net_addr      = '0;
        net_data      = '0;
        check_req     = 1'b0;
        cur_mask      = '0;
        model_err     = 1'b0;
        rnd_seed      = 75;
        model_regs[0] = '0;
        repeat (4) @(posedge clk);
        n_reset <= 1'b1;
        @(negedge clk);
        check_barrier(barrier, '0);
        check_exception(exception, 1'b0);

        for (i = 1; i < 2**`CORE_RF_AW; i++)
        begin
            rnd = $random(rnd_seed);
            load_reg(i, rnd);
        end
        load_mask('1);
        // Packet for node 2, must be ignored
        send_packet(10'd2, NET_REG, 10'd11, 32'hdead_beef);

        // Arithmetic and moves
        load_pc = 0;
        put_instr(OP_ADDU, 1, 2);
        put_instr(OP_SUBU, 3, 4);
        put_instr(OP_AND, 5, 6);
        put_instr(OP_OR, 7, 8);
        put_instr(OP_MOV, 9, 10);
        put_instr(OP_ADDU, 11, 1);
        put_instr(OP_ADDU, 11, 3);
        put_instr(OP_SUBU, 11, 5);
        put_instr(OP_OR, 11, 7);
        put_instr(OP_ADDU, 11, 9);
        put_instr(OP_BAR, 0, 11);
        put_instr(OP_WAIT, 0, 0);
        run_program(0, NO_LIMIT);

        // Dependencies at distance one and two
        load_pc = 32;
        put_instr(OP_ADDU, 12, 13);
        put_instr(OP_ADDU, 14, 12);
        put_instr(OP_SUBU, 14, 12);
        put_instr(OP_MOV, 15, 14);
        put_instr(OP_NOP, 0, 0);
        put_instr(OP_OR, 15, 14);
        put_instr(OP_ADDU, 15, 15);
        put_instr(OP_BAR, 0, 15);
        put_instr(OP_WAIT, 0, 0);
        run_program(32, NO_LIMIT);

        // Countdown loop, skips, call and return
        load_reg(20, 5);
        load_reg(21, 1);
        load_reg(23, 96);
        load_reg(25, -3);
        load_pc = 64;
        put_instr(OP_MOV, 22, 0);
        put_instr(OP_ADDU, 22, 20);
        put_instr(OP_SUBU, 20, 21);
        put_instr(OP_BNEQZ, 20, -2);
        put_instr(OP_BEQZ, 22, 2);
        put_instr(OP_ADDU, 22, 21);
        put_instr(OP_BEQZ, 0, 2);
        put_instr(OP_ADDU, 22, 22);
        put_instr(OP_BLTZ, 25, 2);
        put_instr(OP_ADDU, 22, 22);
        put_instr(OP_BLTZ, 21, 2);
        put_instr(OP_ADDU, 22, 21);
        put_instr(OP_BGTZ, 21, 2);
        put_instr(OP_ADDU, 22, 22);
        put_instr(OP_BGTZ, 25, 2);
        put_instr(OP_JALR, 24, 23);
        put_instr(OP_BAR, 0, 22);
        put_instr(OP_WAIT, 0, 0);
        load_pc = 96;
        put_instr(OP_ADDU, 22, 22);
        put_instr(OP_JALR, 0, 24);
        run_program(64, NO_LIMIT);

        // Random mask, never all zero
        rnd = $random(rnd_seed);
        load_mask(rnd[`CORE_MASK_W-1:0] | 8'h01);
        load_pc = 112;
        put_instr(OP_ADDU, 26, 27);
        put_instr(OP_BAR, 0, 26);
        put_instr(OP_WAIT, 0, 0);
        run_program(112, NO_LIMIT);

        // Restart with a new program
        load_pc = 128;
        put_instr(OP_SUBU, 28, 29);
        put_instr(OP_OR, 28, 30);
        put_instr(OP_BAR, 0, 28);
        put_instr(OP_WAIT, 0, 0);
        run_program(128, NO_LIMIT);

        // Long loop, interrupted by a second start
        load_reg(20, 60);
        load_pc = 144;
        put_instr(OP_BAR, 0, 31);
        put_instr(OP_SUBU, 20, 21);
        put_instr(OP_BNEQZ, 20, -1);
        put_instr(OP_BAR, 0, 30);
        put_instr(OP_WAIT, 0, 0);
        run_program(144, 10);

        // Mask packet in ERR leaves barrier_o alone
        load_mask(~cur_mask);
        repeat (SETTLE_CYCLES) @(posedge clk);
        @(negedge clk);
        check_barrier(barrier, exp_bar);
        check_exception(exception, 1'b1);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/core_pkg.sv
hw/pipe_reg.sv
hw/instr_mem.sv
hw/reg_file.sv
hw/alu.sv
hw/net_ctrl.sv
hw/core.sv
test/core_tb.sv
